/* rtl/iq_cfg_pkg.sv */
// =========================================================
// instruction queue sizing
// depth, retire width and sequence number range
// =========================================================

package iq_cfg_pkg;

	// queue depth in entries
	localparam int IQ_ENTRIES = 8;

	// most head entries retired in one cycle
	localparam int QSLOTS = 2;

	// sequence number width and range split
	localparam int SNBIT = 6;
	// rebase amount and clamp edge
	localparam int SN_QUARTER = 1 << (SNBIT - 2);
	// overflow is raised from here upward
	localparam int SN_TOPQ = 3 * SN_QUARTER;

	// instruction word width
	localparam int PAYLOAD_W = 32;

	// index and counter widths
	localparam int QID_W = $clog2(IQ_ENTRIES);
	// count runs 0 .. IQ_ENTRIES
	localparam int CNT_W = $clog2(IQ_ENTRIES + 1);
	// retire amount runs 0 .. QSLOTS
	localparam int AMT_W = $clog2(QSLOTS + 1);

endpackage

/* rtl/iq_types_pkg.sv */
// =========================================================
// instruction queue types
// indices, sequence numbers, payload and queue entry
// =========================================================

package iq_types_pkg;

	// slot index into the circular queue
	typedef logic [iq_cfg_pkg::QID_W-1:0] qid_t;

	// in-order sequence number
	typedef logic [iq_cfg_pkg::SNBIT-1:0] seqnum_t;

	// raw instruction word as written over the bus
	typedef logic [iq_cfg_pkg::PAYLOAD_W-1:0] payload_t;

	// number of valid entries
	typedef logic [iq_cfg_pkg::CNT_W-1:0] cnt_t;

	// entries retired in one cycle
	typedef logic [iq_cfg_pkg::AMT_W-1:0] amt_t;

	// one queue slot
	typedef struct packed {
		logic     valid;
		seqnum_t  sn;
		payload_t payload;
	} iq_entry_t;

endpackage

/* rtl/iq_view_if.sv */
// =========================================================
// queue view
// entry array and pointers shared by store, seqnum, commit
// =========================================================
`timescale 1ns/1ns

interface iq_view_if;

	// whole entry array, valid or not
	iq_types_pkg::iq_entry_t entries [iq_cfg_pkg::IQ_ENTRIES];
	// head slot and its successors, oldest first
	iq_types_pkg::qid_t heads [iq_cfg_pkg::QSLOTS];
	iq_types_pkg::cnt_t count;

	// from seqnum, already lowered on overflow
	iq_types_pkg::seqnum_t maxsn;
	logic overflow;

	// entries leaving the head this cycle
	iq_types_pkg::amt_t hi_amt;

	modport store (output entries, heads, count, input maxsn, overflow, hi_amt);

	modport seq (input entries, output maxsn, overflow);

	modport commit (input entries, heads, count, output hi_amt);

endinterface

/* rtl/wb_dispatch.sv */
// =========================================================
// wishbone dispatch port
// classic slave, writes enqueue one instruction each
// reads are acked with zero data
// =========================================================
`timescale 1ns/1ns

module wb_dispatch (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   wb_cyc,
	input  logic                   wb_stb,
	input  logic                   wb_we,
	input  iq_types_pkg::payload_t wb_dat_w,
	input  logic                   full,
	output logic                   wb_ack,
	output iq_types_pkg::payload_t wb_dat_r,
	output logic                   wr_en,
	output iq_types_pkg::payload_t wr_payload
);

	logic req;
	logic ack_q;

	assign req = wb_cyc && wb_stb;

	// registered ack one cycle after the request
	// a write waits here while the queue is full
	// ack_q blocks a second ack for the same request
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			ack_q <= 1'b0;
		else
			ack_q <= req && !ack_q && (!wb_we || !full);
	end

	// master dropping stb takes ack away at once
	assign wb_ack = ack_q && req;

	// the acked cycle is the write cycle
	assign wr_en      = wb_ack && wb_we;
	assign wr_payload = wb_dat_w;

	// nothing readable behind this port
	assign wb_dat_r = '0;

	// full is only released by commit, so a write ack
	// must never see a full queue
	a_no_ack_full: assert property (@(posedge clk) disable iff (!rst_n)
		!(wb_ack && wb_we && full))
		else $error("wb_dispatch: write acked while queue full");

endmodule

/* rtl/iq_store.sv */
// =========================================================
// instruction queue store
// circular entry array with head/tail, sequence tagging
// and quarter-range rebase of stored numbers
// =========================================================
`timescale 1ns/1ns

module iq_store (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   wr_en,
	input  iq_types_pkg::payload_t wr_payload,
	output logic                   full,
	output logic                   sn_rebase,
	iq_view_if.store               view
);

	iq_types_pkg::iq_entry_t entries_q [iq_cfg_pkg::IQ_ENTRIES];
	iq_types_pkg::qid_t      head_q;
	iq_types_pkg::qid_t      tail_q;
	iq_types_pkg::cnt_t      count_q;

	// lower by a quarter
	// stale low numbers go to zero
	function automatic iq_types_pkg::seqnum_t sn_lower(input iq_types_pkg::seqnum_t sn);
		if (sn < iq_types_pkg::seqnum_t'(iq_cfg_pkg::SN_QUARTER))
			return '0;
		return iq_types_pkg::seqnum_t'(sn - iq_cfg_pkg::SN_QUARTER);
	endfunction

	// =========================================================
	// entry array and pointers
	// =========================================================
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < iq_cfg_pkg::IQ_ENTRIES; i++)
				entries_q[i] <= '0;
			head_q    <= '0;
			tail_q    <= '0;
			count_q   <= '0;
			sn_rebase <= 1'b0;
		end
		else
		begin
			// rebase every slot, valid or not
			if (view.overflow)
			begin
				for (int i = 0; i < iq_cfg_pkg::IQ_ENTRIES; i++)
					entries_q[i].sn <= sn_lower(entries_q[i].sn);
			end
			// free the retired heads
			for (int s = 0; s < iq_cfg_pkg::QSLOTS; s++)
			begin
				if (s < view.hi_amt)
					entries_q[view.heads[s]].valid <= 1'b0;
			end
			// new entry overrides the rebase of its own slot
			// maxsn is already lowered when overflow is set
			if (wr_en)
				entries_q[tail_q] <= '{valid: 1'b1,
					sn: iq_types_pkg::seqnum_t'(view.maxsn + 1'b1), payload: wr_payload};
			head_q    <= iq_types_pkg::qid_t'(head_q + view.hi_amt);
			tail_q    <= iq_types_pkg::qid_t'(tail_q + wr_en);
			count_q   <= iq_types_pkg::cnt_t'(count_q + wr_en - view.hi_amt);
			// one cycle pulse after the rebase edge
			sn_rebase <= view.overflow;
		end
	end

	// head and successors for the commit stage
	always_comb
	begin
		for (int s = 0; s < iq_cfg_pkg::QSLOTS; s++)
			view.heads[s] = iq_types_pkg::qid_t'(head_q + s);
	end

	assign view.entries = entries_q;
	assign view.count   = count_q;
	assign full = (count_q == iq_types_pkg::cnt_t'(iq_cfg_pkg::IQ_ENTRIES));

	// dispatch must hold off while full
	a_no_wr_full: assert property (@(posedge clk) disable iff (!rst_n)
		wr_en |-> !full)
		else $error("iq_store: write into full queue");

	// tail slot was freed by commit before it is reused
	a_wr_free: assert property (@(posedge clk) disable iff (!rst_n)
		wr_en |-> !entries_q[tail_q].valid)
		else $error("iq_store: write over a valid entry");

	// commit cannot free more than is held
	a_amt_le_count: assert property (@(posedge clk) disable iff (!rst_n)
		view.hi_amt <= view.count)
		else $error("iq_store: hi_amt above count");

endmodule

/* rtl/seqnum.sv */
// =========================================================
// sequence number maximum
// largest stored number and overflow detect, combinational
// =========================================================
`timescale 1ns/1ns

module seqnum (
	iq_view_if.seq view
);

	// maximum before any rebase
	iq_types_pkg::seqnum_t raw_max;

	// scan all slots
	// freed slots still hold the last numbers they carried
	// so the max tracks the newest number handed out
	always_comb
	begin
		raw_max = '0;
		for (int n = 0; n < iq_cfg_pkg::IQ_ENTRIES; n++)
		begin
			if (view.entries[n].sn > raw_max)
				raw_max = view.entries[n].sn;
		end
	end

	// top quarter reached
	assign view.overflow = (raw_max >= iq_types_pkg::seqnum_t'(iq_cfg_pkg::SN_TOPQ));

	// store rebases on this same edge
	// so report the max as it will be after
	assign view.maxsn = view.overflow ?
		iq_types_pkg::seqnum_t'(raw_max - iq_cfg_pkg::SN_QUARTER) : raw_max;

endmodule

/* rtl/iq_commit.sv */
// =========================================================
// in-order commit
// retires up to QSLOTS head entries per cycle on request
// =========================================================
`timescale 1ns/1ns

module iq_commit (
	input  logic                                              clk,
	input  logic                                              rst_n,
	input  iq_types_pkg::amt_t                                retire_req,
	output logic [iq_cfg_pkg::QSLOTS-1:0]                     retire_v,
	output iq_types_pkg::payload_t [iq_cfg_pkg::QSLOTS-1:0]   retire_payload,
	output iq_types_pkg::seqnum_t [iq_cfg_pkg::QSLOTS-1:0]    retire_sn,
	iq_view_if.commit                                         view
);

	// request limited by what the queue holds
	assign view.hi_amt = (retire_req > view.count) ?
		iq_types_pkg::amt_t'(view.count) : retire_req;

	// slot valids
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			retire_v <= '0;
		else
		begin
			for (int s = 0; s < iq_cfg_pkg::QSLOTS; s++)
				retire_v[s] <= (s < view.hi_amt);
		end
	end

	// slot data, slot 0 is the oldest
	// meaningful only where retire_v is set
	always_ff @(posedge clk)
	begin
		for (int s = 0; s < iq_cfg_pkg::QSLOTS; s++)
		begin
			retire_payload[s] <= view.entries[view.heads[s]].payload;
			retire_sn[s]      <= view.entries[view.heads[s]].sn;
		end
	end

	// =========================================================
	// checks
	// =========================================================
	// store tags consecutive numbers and rebases them together
	for (genvar s = 1; s < iq_cfg_pkg::QSLOTS; s++)
	begin : g_sn_chk
		a_sn_step: assert property (@(posedge clk) disable iff (!rst_n)
			retire_v[s] |-> retire_v[s-1] &&
				(retire_sn[s] == iq_types_pkg::seqnum_t'(retire_sn[s-1] + 1'b1)))
			else $error("iq_commit: slot %0d sn not one above slot %0d", s, s - 1);
	end

endmodule

/* rtl/iq_seq_top.sv */
// =========================================================
// sequence tracking slice top
// wishbone dispatch, queue store, seqnum and commit
// =========================================================
`timescale 1ns/1ns

module iq_seq_top (
	input  logic                                              clk,
	input  logic                                              rst_n,
	// wishbone slave
	input  logic                                              wb_cyc,
	input  logic                                              wb_stb,
	input  logic                                              wb_we,
	input  iq_types_pkg::payload_t                            wb_dat_w,
	output logic                                              wb_ack,
	output iq_types_pkg::payload_t                            wb_dat_r,
	// retirement
	input  iq_types_pkg::amt_t                                retire_req,
	output logic [iq_cfg_pkg::QSLOTS-1:0]                     retire_v,
	output iq_types_pkg::payload_t [iq_cfg_pkg::QSLOTS-1:0]   retire_payload,
	output iq_types_pkg::seqnum_t [iq_cfg_pkg::QSLOTS-1:0]    retire_sn,
	output logic                                              sn_rebase
);

	// dispatch to store
	logic                   wr_en;
	iq_types_pkg::payload_t wr_payload;
	logic                   full;

	iq_view_if view_i ();

	wb_dispatch dispatch_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_dat_w   (wb_dat_w),
		.full       (full),
		.wb_ack     (wb_ack),
		.wb_dat_r   (wb_dat_r),
		.wr_en      (wr_en),
		.wr_payload (wr_payload)
	);

	iq_store store_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.wr_en      (wr_en),
		.wr_payload (wr_payload),
		.full       (full),
		.sn_rebase  (sn_rebase),
		.view       (view_i.store)
	);

	seqnum seqnum_i (
		.view (view_i.seq)
	);

	iq_commit commit_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.retire_req     (retire_req),
		.retire_v       (retire_v),
		.retire_payload (retire_payload),
		.retire_sn      (retire_sn),
		.view           (view_i.commit)
	);

endmodule

/* testbench/tb_iq_seq.sv */
// ============================================================
// testbench for the sequence tracking slice
// wishbone writes, random retirement, shadow queue model
// ============================================================
`timescale 1ns/1ns

module tb_iq_seq;

	localparam int TIMEOUT = 60;
	// retire request modes
	localparam int RM_NONE  = 0;
	localparam int RM_RAND  = 1;
	localparam int RM_SLOW  = 2;
	localparam int RM_DRAIN = 3;

	logic clk;
	logic rst_n;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	iq_types_pkg::payload_t wb_dat_w;
	logic wb_ack;
	iq_types_pkg::payload_t wb_dat_r;
	iq_types_pkg::amt_t retire_req;
	logic [iq_cfg_pkg::QSLOTS-1:0] retire_v;
	iq_types_pkg::payload_t [iq_cfg_pkg::QSLOTS-1:0] retire_payload;
	iq_types_pkg::seqnum_t [iq_cfg_pkg::QSLOTS-1:0] retire_sn;
	logic sn_rebase;

	// shadow queue with the oldest entry first
	iq_types_pkg::payload_t q_pl [$];
	int q_sn [$];
	// newest number handed out
	int last_sn;

	int errors;
	int acked;
	// slots the DUT marked valid on the retire ports
	int retired;
	// sn_rebase pulses seen
	int rebases;
	int rmode;
	string test_name;

	iq_seq_top dut_i (.*);

	initial
	begin
		clk = 1'b0;
		forever
			#4 clk = ~clk;
	end

	function automatic void report_mismatch(string what, longint expv, longint actv);
		errors++;
		$display("mismatch %s %s: expected %0h actual %0h", test_name, what, expv, actv);
	endfunction

	function automatic void report_error(string msg);
		errors++;
		$display("error in %s: %s", test_name, msg);
	endfunction

	// ============================================================
	// protocol checks
	// ============================================================
	a_ack_once: assert property (@(posedge clk) disable iff (!rst_n) wb_ack |=> !wb_ack)
		else report_error("wb_ack high for two cycles in a row");
	a_rebase_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		sn_rebase |=> !sn_rebase)
		else report_error("sn_rebase longer than one cycle");
	a_slot_order: assert property (@(posedge clk) disable iff (!rst_n)
		retire_v[1] |-> retire_v[0])
		else report_error("slot 1 retired without slot 0");

	// drive retire_req for one clock and step the model over the next edge
	// then compare the registered outputs at the falling edge
	task automatic next_cycle(input bit wr);
		int amt;
		bit exp_reb;
		logic [iq_cfg_pkg::QSLOTS-1:0] exp_v;
		iq_types_pkg::payload_t exp_pl [iq_cfg_pkg::QSLOTS];
		int exp_sn [iq_cfg_pkg::QSLOTS];
		case (rmode)
			RM_RAND:  retire_req = iq_types_pkg::amt_t'($urandom_range(0, 2));
			RM_SLOW:  retire_req = iq_types_pkg::amt_t'($urandom_range(0, 3) == 0);
			RM_DRAIN: retire_req = iq_types_pkg::amt_t'(2);
			default:  retire_req = '0;
		endcase
		// heads leave with the numbers they hold before any rebase
		amt = (retire_req < q_pl.size()) ? retire_req : q_pl.size();
		exp_v = '0;
		for (int s = 0; s < amt; s++)
		begin
			exp_v[s] = 1'b1;
			exp_pl[s] = q_pl.pop_front();
			exp_sn[s] = q_sn.pop_front();
		end
		// newest number in the top quarter lowers everything held
		exp_reb = (last_sn >= iq_cfg_pkg::SN_TOPQ);
		if (exp_reb)
		begin
			last_sn -= iq_cfg_pkg::SN_QUARTER;
			foreach (q_sn[i])
				q_sn[i] = (q_sn[i] < iq_cfg_pkg::SN_QUARTER) ?
					0 : q_sn[i] - iq_cfg_pkg::SN_QUARTER;
		end
		if (wr)
		begin
			last_sn++;
			q_pl.push_back(wb_dat_w);
			q_sn.push_back(last_sn);
			acked++;
		end
		@(negedge clk);
		assert (retire_v == exp_v) else report_mismatch("retire_v", exp_v, retire_v);
		for (int s = 0; s < amt; s++)
		begin
			assert (retire_payload[s] == exp_pl[s])
				else report_mismatch("retire_payload", exp_pl[s], retire_payload[s]);
			assert (retire_sn[s] == exp_sn[s])
				else report_mismatch("retire_sn", exp_sn[s], retire_sn[s]);
		end
		for (int s = 0; s < iq_cfg_pkg::QSLOTS; s++)
		begin
			if (retire_v[s])
				retired++;
		end
		assert (sn_rebase == exp_reb) else report_mismatch("sn_rebase", exp_reb, sn_rebase);
		if (sn_rebase)
			rebases++;
	endtask

	// hold a write until acked
	// the write lands on the edge after ack
	// hold > 0 first expects that many cycles without ack on a full queue
	task automatic bus_write(input iq_types_pkg::payload_t data, input int hold);
		bit got;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b1;
		wb_dat_w = data;
		got = 1'b0;
		for (int h = 0; h < hold; h++)
		begin
			next_cycle(1'b0);
			assert (!wb_ack) else report_error("write acked while the queue was full");
		end
		if (hold > 0)
			rmode = RM_SLOW;
		for (int t = 0; t < TIMEOUT && !got; t++)
		begin
			next_cycle(1'b0);
			got = wb_ack;
		end
		if (got)
			next_cycle(1'b1);
		else
			report_error("timeout waiting for wb_ack");
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	// a read is acked with zero data and enqueues nothing
	task automatic bus_read();
		bit got;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b0;
		got = 1'b0;
		for (int t = 0; t < TIMEOUT && !got; t++)
		begin
			next_cycle(1'b0);
			got = wb_ack;
		end
		if (got)
		begin
			assert (wb_dat_r == '0) else report_mismatch("wb_dat_r", 0, wb_dat_r);
			next_cycle(1'b0);
		end
		else
		begin
			report_error("timeout waiting for wb_ack on read");
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
	endtask

	task automatic drain();
		rmode = RM_DRAIN;
		for (int t = 0; t < TIMEOUT && q_pl.size() > 0; t++)
			next_cycle(1'b0);
		assert (q_pl.size() == 0) else report_error("timeout draining the queue");
	endtask

	// ============================================================
	// test sequence
	// ============================================================
	initial
	begin
		void'($urandom(34727));
		errors = 0;
		acked = 0;
		retired = 0;
		rebases = 0;
		last_sn = 0;
		rmode = RM_NONE;
		rst_n = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_dat_w = '0;
		retire_req = '0;
		test_name = "reset";
		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		assert (!wb_ack && retire_v == '0 && !sn_rebase)
			else report_error("outputs not idle after reset");
		// first instruction after reset is numbered 1
		bus_write($urandom(), 0);
		rmode = RM_DRAIN;
		next_cycle(1'b0);
		assert (retire_v[0] && retire_sn[0] == 1)
			else report_mismatch("first sn", 1, retire_sn[0]);

		test_name = "read";
		bus_read();

		test_name = "order";
		rmode = RM_RAND;
		repeat (40) bus_write($urandom(), 0);
		drain();

		// slow retirement carries the numbers through several rebases
		test_name = "rebase";
		rebases = 0;
		rmode = RM_SLOW;
		repeat (60) bus_write($urandom(), 0);
		drain();
		assert (rebases >= 3) else report_error("too few sn_rebase pulses seen");

		test_name = "full";
		rmode = RM_NONE;
		repeat (iq_cfg_pkg::IQ_ENTRIES) bus_write($urandom(), 0);
		bus_write($urandom(), 6);
		drain();
		assert (acked == retired) else report_mismatch("retired count", acked, retired);

		$display("closing: %0d errors, %0d acked, %0d retired", errors, acked, retired);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* build.f */
rtl/iq_cfg_pkg.sv
rtl/iq_types_pkg.sv
rtl/iq_view_if.sv
rtl/wb_dispatch.sv
rtl/iq_store.sv
rtl/seqnum.sv
rtl/iq_commit.sv
rtl/iq_seq_top.sv
testbench/tb_iq_seq.sv

/* Bender.yml */
package:
  name: iq_seq

sources:
  - rtl/iq_cfg_pkg.sv
  - rtl/iq_types_pkg.sv
  - rtl/iq_view_if.sv
  - rtl/wb_dispatch.sv
  - rtl/iq_store.sv
  - rtl/seqnum.sv
  - rtl/iq_commit.sv
  - rtl/iq_seq_top.sv
  - target: test
    files:
      - testbench/tb_iq_seq.sv
